//--- Makefile
VERILATOR = verilator
TOP = icache_tb

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q '\*\*\* TEST PASSED \*\*\*'

clean:
	rm -rf obj_dir

//--- rtl/icache.sv
`timescale 1ns/1ps

module icache #(
  parameter int set_bits       = 5,
  parameter int queue_depth    = 8,
  parameter int prefetch_lines = 2
) (
  input  logic                 clock,
  input  logic                 reset,
  input  icache_pkg::addr_t    fetch_addr,
  output icache_pkg::word_t    fetch_data,
  output logic                 fetch_valid,
  output icache_pkg::bus_cmd_e mem_cmd,
  output icache_pkg::addr_t    mem_addr,
  input  icache_pkg::mem_tag_t mem_response,
  input  icache_pkg::word_t    mem_data,
  input  icache_pkg::mem_tag_t mem_tag
);

  icache_pkg::queue_entry_t [queue_depth-1:0]  entries;
  icache_pkg::enq_req_t     [prefetch_lines:0] enq;
  icache_pkg::issue_slot_t                     slot;
  icache_pkg::issue_result_t                   result;
  icache_pkg::fill_t                           fill;
  icache_pkg::addr_t                           probe_addr;
  icache_pkg::addr_t                           wr_addr;
  icache_pkg::word_t                           wr_data;
  logic                                        probe_hit;
  logic                                        wr_en;

  assign fill = '{tag: mem_tag, data: mem_data};

  icache_mem #(.set_bits(set_bits)) mem_i (
    .clock(clock), .reset(reset),
    .rd1_addr(fetch_addr), .rd2_addr(probe_addr),
    .rd1_data(fetch_data), .rd1_hit(fetch_valid), .rd2_hit(probe_hit),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  prefetch_gen #(.queue_depth(queue_depth), .prefetch_lines(prefetch_lines)) prefetch_i (
    .clock(clock), .reset(reset),
    .fetch_addr(fetch_addr), .fetch_hit(fetch_valid),
    .queue_entries(entries), .enq(enq)
  );

  miss_queue #(.queue_depth(queue_depth), .prefetch_lines(prefetch_lines)) queue_i (
    .clock(clock), .reset(reset),
    .enq(enq), .entries(entries), .slot(slot), .result(result), .fill(fill),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
  );

  mem_issuer issuer_i (
    .clock(clock), .reset(reset),
    .slot(slot), .probe_addr(probe_addr), .probe_hit(probe_hit), .result(result),
    .mem_cmd(mem_cmd), .mem_addr(mem_addr), .mem_response(mem_response)
  );

endmodule

//--- rtl/icache_mem.sv
`timescale 1ns/1ps

module icache_mem #(
  parameter int set_bits = 5
) (
  input  logic              clock,
  input  logic              reset,
  input  icache_pkg::addr_t rd1_addr,
  input  icache_pkg::addr_t rd2_addr,
  output icache_pkg::word_t rd1_data,
  output logic              rd1_hit,
  output logic              rd2_hit,
  input  logic              wr_en,
  input  icache_pkg::addr_t wr_addr,
  input  icache_pkg::word_t wr_data
);

  localparam int num_sets = 2 ** set_bits;
  localparam int tag_bits = 32 - icache_pkg::offset_bits - set_bits;

  logic [num_sets-1:0] valid_arr;
  logic [tag_bits-1:0] tag_arr [num_sets];
  icache_pkg::word_t   data_arr [num_sets];

  logic [set_bits-1:0] rd1_idx;
  logic [set_bits-1:0] rd2_idx;
  logic [set_bits-1:0] wr_idx;
  logic [tag_bits-1:0] rd1_tag;
  logic [tag_bits-1:0] rd2_tag;
  logic [tag_bits-1:0] wr_tag;

  // byte offset bits are dropped, the rest splits into index and tag
  assign rd1_idx = rd1_addr[icache_pkg::offset_bits +: set_bits];
  assign rd2_idx = rd2_addr[icache_pkg::offset_bits +: set_bits];
  assign wr_idx  = wr_addr[icache_pkg::offset_bits +: set_bits];
  assign rd1_tag = rd1_addr[icache_pkg::offset_bits + set_bits +: tag_bits];
  assign rd2_tag = rd2_addr[icache_pkg::offset_bits + set_bits +: tag_bits];
  assign wr_tag  = wr_addr[icache_pkg::offset_bits + set_bits +: tag_bits];

  //////////////////////////////
  // lookup ports
  //////////////////////////////

  assign rd1_hit  = valid_arr[rd1_idx] && (tag_arr[rd1_idx] == rd1_tag);
  assign rd1_data = data_arr[rd1_idx];
  assign rd2_hit  = valid_arr[rd2_idx] && (tag_arr[rd2_idx] == rd2_tag);

  //////////////////////////////
  // fill port
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_arr <= '0;
      for (int i = 0; i < num_sets; i++) begin
        tag_arr[i]  <= '0;
        data_arr[i] <= '0;
      end
    end else if (wr_en) begin
      valid_arr[wr_idx] <= 1'b1;
      tag_arr[wr_idx]   <= wr_tag;
      data_arr[wr_idx]  <= wr_data;
    end
  end

  // fill address comes from the queue head
  a_wr_addr_known: assert property (
    @(posedge clock) disable iff (reset)
    wr_en |-> !$isunknown(wr_addr)
  );

endmodule

//--- rtl/icache_pkg.sv
package icache_pkg;

  localparam int line_bytes = 8;
  localparam int offset_bits = 3;

  typedef logic [31:0] addr_t;
  typedef logic [63:0] word_t;
  typedef logic [3:0]  mem_tag_t;
  typedef logic [3:0]  queue_pos_t;

  typedef enum logic [1:0] {
    bus_none = 2'd0,
    bus_load = 2'd1
  } bus_cmd_e;

  // life of one miss queue slot
  typedef enum logic [1:0] {
    ent_empty  = 2'd0,
    ent_wait   = 2'd1,
    ent_issued = 2'd2,
    ent_skip   = 2'd3
  } entry_state_e;

  typedef struct packed {
    addr_t        line_addr;
    entry_state_e state;
    mem_tag_t     tag;
  } queue_entry_t;

  typedef struct packed {
    logic       valid;
    queue_pos_t pos;
    addr_t      line_addr;
  } issue_slot_t;

  typedef struct packed {
    logic       valid;
    logic       skip;
    queue_pos_t pos;
    mem_tag_t   tag;
  } issue_result_t;

  typedef struct packed {
    mem_tag_t tag;
    word_t    data;
  } fill_t;

  typedef struct packed {
    logic  valid;
    addr_t line_addr;
  } enq_req_t;

endpackage

//--- rtl/mem_issuer.sv
`timescale 1ns/1ps

module mem_issuer (
  input  logic                      clock,
  input  logic                      reset,
  input  icache_pkg::issue_slot_t   slot,
  output icache_pkg::addr_t         probe_addr,
  input  logic                      probe_hit,
  output icache_pkg::issue_result_t result,
  output icache_pkg::bus_cmd_e      mem_cmd,
  output icache_pkg::addr_t         mem_addr,
  input  icache_pkg::mem_tag_t      mem_response
);

  typedef enum logic {
    st_idle,
    st_request
  } state_e;

  state_e            state;
  icache_pkg::addr_t held_addr;
  logic              held_match;
  logic              granted;

  assign probe_addr = slot.line_addr;

  // the held entry stays oldest waiting, slot.pos follows it down the queue
  assign held_match = slot.valid && (slot.line_addr == held_addr);
  assign granted    = (state == st_request) && held_match && (mem_response != '0);

  assign mem_cmd  = (state == st_request && held_match) ? icache_pkg::bus_load
                                                        : icache_pkg::bus_none;
  assign mem_addr = (state == st_request) ? held_addr : '0;

  always_comb begin
    result = '0;
    if (state == st_idle && slot.valid && probe_hit) begin
      result.valid = 1'b1;
      result.skip  = 1'b1;
      result.pos   = slot.pos;
    end else if (granted) begin
      result.valid = 1'b1;
      result.pos   = slot.pos;
      result.tag   = mem_response;
    end
  end

  //////////////////////////////
  // FSM
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (slot.valid && !probe_hit) begin
            state <= st_request;
          end
        end
        st_request: begin
          if (granted || !held_match) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == st_idle && slot.valid && !probe_hit) begin
      held_addr <= slot.line_addr;
    end
  end

  // busy memory, so the same load comes back next cycle
  a_busy_retry: assert property (
    @(posedge clock) disable iff (reset)
    (state == st_request && mem_cmd == icache_pkg::bus_load && mem_response == '0)
      |=> (mem_cmd == icache_pkg::bus_load && $stable(mem_addr))
  );

endmodule

//--- rtl/miss_queue.sv
`timescale 1ns/1ps

module miss_queue #(
  parameter int queue_depth    = 8,
  parameter int prefetch_lines = 2
) (
  input  logic                                        clock,
  input  logic                                        reset,
  input  icache_pkg::enq_req_t     [prefetch_lines:0] enq,
  output icache_pkg::queue_entry_t [queue_depth-1:0]  entries,
  output icache_pkg::issue_slot_t                     slot,
  input  icache_pkg::issue_result_t                   result,
  input  icache_pkg::fill_t                           fill,
  output logic                                        wr_en,
  output icache_pkg::addr_t                           wr_addr,
  output icache_pkg::word_t                           wr_data
);

  localparam int tail_bits = $clog2(queue_depth + 1);

  icache_pkg::queue_entry_t [queue_depth-1:0] q;
  icache_pkg::queue_entry_t [queue_depth-1:0] q_next;
  logic [tail_bits-1:0] tail;
  logic [tail_bits-1:0] tail_next;
  logic pop_fill;
  logic pop_skip;
  logic pop;

  // memory returns in issue order, so only the head can match
  assign pop_fill = (q[0].state == icache_pkg::ent_issued) &&
                    (fill.tag != '0) && (fill.tag == q[0].tag);
  assign pop_skip = (q[0].state == icache_pkg::ent_skip);
  assign pop      = pop_fill || pop_skip;

  assign wr_en   = pop_fill;
  assign wr_addr = q[0].line_addr;
  assign wr_data = fill.data;
  assign entries = q;

  // oldest entry still waiting to go out
  always_comb begin
    slot = '0;
    for (int i = queue_depth - 1; i >= 0; i--) begin
      if (q[i].state == icache_pkg::ent_wait) begin
        slot.valid     = 1'b1;
        slot.pos       = icache_pkg::queue_pos_t'(i);
        slot.line_addr = q[i].line_addr;
      end
    end
  end

  //////////////////////////////
  // pop, update, append
  //////////////////////////////

  always_comb begin
    icache_pkg::queue_pos_t res_pos;
    q_next    = q;
    tail_next = tail;
    res_pos   = result.pos;

    if (pop) begin
      for (int i = 0; i < queue_depth - 1; i++) begin
        q_next[i] = q[i+1];
      end
      q_next[queue_depth-1] = '0;
      tail_next = tail - 1'b1;
      // result position was taken before the shift
      res_pos = result.pos - 1'b1;
    end

    if (result.valid) begin
      if (result.skip) begin
        q_next[res_pos].state = icache_pkg::ent_skip;
      end else begin
        q_next[res_pos].state = icache_pkg::ent_issued;
        q_next[res_pos].tag   = result.tag;
      end
    end

    // requests past a full queue are dropped
    for (int k = 0; k <= prefetch_lines; k++) begin
      if (enq[k].valid && tail_next < queue_depth) begin
        q_next[tail_next] = '{line_addr: enq[k].line_addr,
                              state:     icache_pkg::ent_wait,
                              tag:       '0};
        tail_next = tail_next + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      q    <= '0;
      tail <= '0;
    end else begin
      q    <= q_next;
      tail <= tail_next;
    end
  end

  a_tail_bound: assert property (
    @(posedge clock) disable iff (reset)
    tail <= queue_depth
  );

  // every returned fill must land on an issued head
  a_write_issued: assert property (
    @(posedge clock) disable iff (reset)
    (fill.tag != '0) |-> (q[0].state == icache_pkg::ent_issued && fill.tag == q[0].tag)
  );

endmodule

//--- rtl/prefetch_gen.sv
`timescale 1ns/1ps

module prefetch_gen #(
  parameter int queue_depth    = 8,
  parameter int prefetch_lines = 2
) (
  input  logic                                        clock,
  input  logic                                        reset,
  input  icache_pkg::addr_t                           fetch_addr,
  input  logic                                        fetch_hit,
  input  icache_pkg::queue_entry_t [queue_depth-1:0]  queue_entries,
  output icache_pkg::enq_req_t     [prefetch_lines:0] enq
);

  localparam icache_pkg::addr_t line_mask = icache_pkg::addr_t'(icache_pkg::line_bytes - 1);

  icache_pkg::addr_t                    last_addr;
  icache_pkg::addr_t [prefetch_lines:0] line_addr;
  logic              [prefetch_lines:0] in_queue;
  logic                                 addr_changed;

  always_ff @(posedge clock) begin
    if (reset) begin
      last_addr <= '1;
    end else begin
      last_addr <= fetch_addr;
    end
  end

  assign addr_changed = (fetch_addr != last_addr);

  //////////////////////////////
  // line addresses and CAM
  //////////////////////////////

  // element 0 is the demand line, then the lines after it
  always_comb begin
    for (int k = 0; k <= prefetch_lines; k++) begin
      line_addr[k] = (fetch_addr & ~line_mask) +
                     icache_pkg::addr_t'(k * icache_pkg::line_bytes);
      in_queue[k] = 1'b0;
      for (int i = 0; i < queue_depth; i++) begin
        if (queue_entries[i].state != icache_pkg::ent_empty &&
            queue_entries[i].line_addr == line_addr[k]) begin
          in_queue[k] = 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int k = 0; k <= prefetch_lines; k++) begin
      enq[k].line_addr = line_addr[k];
      enq[k].valid     = addr_changed && !in_queue[k];
    end
    // demand keeps asking while it misses
    enq[0].valid = !fetch_hit && !in_queue[0];
  end

endmodule

//--- test/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

  localparam int set_bits       = 5;
  localparam int queue_depth    = 8;
  localparam int prefetch_lines = 2;
  localparam int row_timeout    = 200;

  typedef struct packed {
    icache_pkg::addr_t addr;
    logic              no_new_load;
  } row_t;

  logic                 clock;
  logic                 reset;
  icache_pkg::addr_t    fetch_addr;
  icache_pkg::word_t    fetch_data;
  logic                 fetch_valid;
  icache_pkg::bus_cmd_e mem_cmd;
  icache_pkg::addr_t    mem_addr;
  icache_pkg::mem_tag_t mem_response;
  icache_pkg::word_t    mem_data;
  icache_pkg::mem_tag_t mem_tag;

  row_t rows [$];
  bit   allowed [icache_pkg::addr_t];

  icache #(
    .set_bits(set_bits),
    .queue_depth(queue_depth),
    .prefetch_lines(prefetch_lines)
  ) dut_i (
    .clock(clock), .reset(reset),
    .fetch_addr(fetch_addr), .fetch_data(fetch_data), .fetch_valid(fetch_valid),
    .mem_cmd(mem_cmd), .mem_addr(mem_addr), .mem_response(mem_response),
    .mem_data(mem_data), .mem_tag(mem_tag)
  );

  mem_model #(.latency(5)) model_i (
    .clock(clock), .reset(reset),
    .mem_cmd(mem_cmd), .mem_addr(mem_addr), .mem_response(mem_response),
    .mem_data(mem_data), .mem_tag(mem_tag)
  );

  always #20 clock = ~clock;

  //////////////////////////////
  // helpers and compare tasks
  //////////////////////////////

  task automatic fail_with(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input icache_pkg::word_t got,
                            input icache_pkg::word_t exp);
    if (got !== exp) begin
      fail_with($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input icache_pkg::addr_t got,
                            input icache_pkg::addr_t exp);
    if (got !== exp) begin
      fail_with($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input integer got, input integer exp);
    if (got !== exp) begin
      fail_with($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_cmd(input string name, input icache_pkg::bus_cmd_e got,
                           input icache_pkg::bus_cmd_e exp);
    if (got !== exp) begin
      fail_with($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  function automatic icache_pkg::addr_t line_of(input icache_pkg::addr_t a);
    return a & ~icache_pkg::addr_t'(7);
  endfunction

  // upper half the line address, lower half its inversion
  function automatic icache_pkg::word_t expected_word(input icache_pkg::addr_t a);
    return {line_of(a), ~line_of(a)};
  endfunction

  function automatic integer count_of(input icache_pkg::addr_t line);
    if (model_i.loads.exists(line)) begin
      return model_i.loads[line];
    end
    return 0;
  endfunction

  // demand line plus the lines that may be prefetched with it
  task automatic note_lines(input icache_pkg::addr_t a);
    for (int k = 0; k <= prefetch_lines; k++) begin
      allowed[line_of(a) + icache_pkg::addr_t'(k * 8)] = 1'b1;
    end
  endtask

  task automatic add_row(input icache_pkg::addr_t a, input logic no_new_load);
    row_t r;
    r.addr        = a;
    r.no_new_load = no_new_load;
    rows.push_back(r);
  endtask

  // every granted load must be an aligned, requested line
  always @(posedge clock) begin
    if (!reset && mem_cmd == icache_pkg::bus_load && mem_response != '0) begin
      check_addr("mem_addr", mem_addr, line_of(mem_addr));
      if (!allowed.exists(mem_addr)) begin
        fail_with($sformatf("load granted for line %h that was never requested", mem_addr));
      end
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    int   waited;
    logic seen;

    add_row(32'h000, 1'b0);
    add_row(32'h008, 1'b1);
    add_row(32'h010, 1'b1);
    add_row(32'h044, 1'b0);
    add_row(32'h04c, 1'b1);
    add_row(32'h050, 1'b1);
    add_row(32'h004, 1'b0);
    add_row(32'h060, 1'b0);
    add_row(32'h068, 1'b1);
    add_row(32'h070, 1'b1);
    add_row(32'h078, 1'b1);
    add_row(32'h080, 1'b0);
    add_row(32'h088, 1'b1);
    add_row(32'h0a0, 1'b0);
    add_row(32'h0b4, 1'b0);
    add_row(32'h0c0, 1'b0);
    add_row(32'h0c8, 1'b1);
    add_row(32'h0d6, 1'b1);
    add_row(32'h0e0, 1'b0);
    add_row(32'h0e8, 1'b1);

    clock      = 1'b0;
    reset      = 1'b1;
    fetch_addr = rows[0].addr;
    note_lines(rows[0].addr);
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    // enqueue then registered probe, so no load in the first two cycles
    for (int c = 0; c < 5; c++) begin
      @(posedge clock);
      if (c < 2) begin
        check_cmd("mem_cmd", mem_cmd, icache_pkg::bus_none);
      end
      if (fetch_valid !== 1'b0) begin
        fail_with($sformatf("fetch_valid high in cycle %0d after reset", c));
      end
    end
    @(negedge clock);

    for (int i = 0; i < rows.size(); i++) begin
      fetch_addr = rows[i].addr;
      note_lines(rows[i].addr);
      seen   = 1'b0;
      waited = 0;
      while (!seen) begin
        @(posedge clock);
        if (fetch_valid === 1'b1) begin
          seen = 1'b1;
        end else begin
          waited++;
          if (waited >= row_timeout) begin
            fail_with($sformatf("timeout waiting for fetch_valid on row %0d", i));
          end
        end
      end
      check_word("fetch_data", fetch_data, expected_word(rows[i].addr));
      @(posedge clock);
      if (fetch_valid !== 1'b1) begin
        fail_with($sformatf("no hit on the repeated fetch of row %0d", i));
      end
      check_word("fetch_data", fetch_data, expected_word(rows[i].addr));
      @(negedge clock);
      if (rows[i].no_new_load) begin
        check_count("loads of prefetched line", count_of(line_of(rows[i].addr)), 1);
      end
    end

    // no set conflicts in this range, so each line loads at most once
    foreach (allowed[a]) begin
      if (count_of(a) > 1) begin
        check_count("loads of line", count_of(a), 1);
      end
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- test/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
  parameter int latency = 5
) (
  input  logic                 clock,
  input  logic                 reset,
  input  icache_pkg::bus_cmd_e mem_cmd,
  input  icache_pkg::addr_t    mem_addr,
  output icache_pkg::mem_tag_t mem_response,
  output icache_pkg::word_t    mem_data,
  output icache_pkg::mem_tag_t mem_tag
);

  integer               seed = 81;
  logic                 busy;
  logic                 grant;
  icache_pkg::mem_tag_t next_tag;
  icache_pkg::mem_tag_t tag_pipe [latency];
  icache_pkg::addr_t    addr_pipe [latency];
  icache_pkg::addr_t    ret_line;
  int unsigned          loads [icache_pkg::addr_t];

  assign grant        = (mem_cmd == icache_pkg::bus_load) && !busy;
  assign mem_response = grant ? next_tag : '0;

  // returned word carries its own line address
  assign ret_line = addr_pipe[latency-1] & ~icache_pkg::addr_t'(7);
  assign mem_tag  = tag_pipe[latency-1];
  assign mem_data = {ret_line, ~ret_line};

  always @(posedge clock) begin
    if (reset) begin
      busy     <= 1'b0;
      next_tag <= 4'h1;
      for (int i = 0; i < latency; i++) begin
        tag_pipe[i]  <= '0;
        addr_pipe[i] <= '0;
      end
    end else begin
      // roughly one cycle in four is busy
      busy         <= (($random(seed) & 3) == 0);
      tag_pipe[0]  <= mem_response;
      addr_pipe[0] <= mem_addr;
      for (int i = 1; i < latency; i++) begin
        tag_pipe[i]  <= tag_pipe[i-1];
        addr_pipe[i] <= addr_pipe[i-1];
      end
      if (grant) begin
        next_tag <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;
      end
    end
  end

  // loads per line address
  always @(posedge clock) begin
    if (!reset && grant) begin
      if (loads.exists(mem_addr)) begin
        loads[mem_addr] = loads[mem_addr] + 1;
      end else begin
        loads[mem_addr] = 1;
      end
    end
  end

endmodule

//--- verilog.f
rtl/icache_pkg.sv
rtl/icache_mem.sv
rtl/prefetch_gen.sv
rtl/miss_queue.sv
rtl/mem_issuer.sv
rtl/icache.sv
test/mem_model.sv
test/icache_tb.sv
